/* verilog.f */
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_ctrl.sv
hdl/mem_bank.sv
hdl/mem_resp_route.sv
hdl/mem_system.sv
verif/mem_checker.sv
verif/mem_system_tb.sv

/* Makefile */
TOP := mem_system_tb
SOURCES := verilog.f $(wildcard hdl/*.sv hdl/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP) -o V$(TOP)

# Fails unless the pass line shows up in the output
run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "RESULT: PASS"

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f verilog.f \
		--top-module $(TOP)

clean:
	rm -rf obj_dir

/* verif/mem_system_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_system_tb import mem_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int N_BLOCKS   = 1 << `MEM_ADDR_WIDTH;
    localparam int N_RANDOM   = 200;
    localparam int N_HALF     = N_RANDOM / 2;
    localparam int WAIT_LIMIT = 40;

    logic                   clk;
    logic                   arst_n;
    logic                   icache_req_valid;
    main_mem_block_addr_t   icache_req_block_addr;
    wire                    icache_req_ready;
    wire                    icache_resp_valid;
    wire block_data_t       icache_resp_block_data;
    logic                   dcache_req_valid;
    req_type_t              dcache_req_type;
    main_mem_block_addr_t   dcache_req_block_addr;
    block_data_t            dcache_req_block_data;
    wire                    dcache_req_ready;
    wire                    dcache_resp_valid;
    wire block_data_t       dcache_resp_block_data;

    int                     chk_errors;
    int                     chk_resps;
    int                     chk_pending;
    integer                 seed;
    int                     tb_errors;
    int                     test_num;
    int                     tests_failed;
    int                     errors_at_start;
    string                  test_name;
    main_mem_block_addr_t   addr_tmp;

    // Random traffic rolled before it is driven
    main_mem_block_addr_t   rnd_ic_addr [N_HALF];
    int                     rnd_ic_gap [N_HALF];
    req_type_t              rnd_dc_type [N_HALF];
    main_mem_block_addr_t   rnd_dc_addr [N_HALF];
    block_data_t            rnd_dc_data [N_HALF];
    int                     rnd_dc_gap [N_HALF];

    mem_system u_mem_system (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .icache_req_valid       (icache_req_valid),
        .icache_req_block_addr  (icache_req_block_addr),
        .icache_req_ready       (icache_req_ready),
        .icache_resp_valid      (icache_resp_valid),
        .icache_resp_block_data (icache_resp_block_data),
        .dcache_req_valid       (dcache_req_valid),
        .dcache_req_type        (dcache_req_type),
        .dcache_req_block_addr  (dcache_req_block_addr),
        .dcache_req_block_data  (dcache_req_block_data),
        .dcache_req_ready       (dcache_req_ready),
        .dcache_resp_valid      (dcache_resp_valid),
        .dcache_resp_block_data (dcache_resp_block_data)
    );

    mem_checker u_mem_checker (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .icache_req_valid       (icache_req_valid),
        .icache_req_block_addr  (icache_req_block_addr),
        .icache_req_ready       (icache_req_ready),
        .icache_resp_valid      (icache_resp_valid),
        .icache_resp_block_data (icache_resp_block_data),
        .dcache_req_valid       (dcache_req_valid),
        .dcache_req_type        (dcache_req_type),
        .dcache_req_block_addr  (dcache_req_block_addr),
        .dcache_req_block_data  (dcache_req_block_data),
        .dcache_req_ready       (dcache_req_ready),
        .dcache_resp_valid      (dcache_resp_valid),
        .dcache_resp_block_data (dcache_resp_block_data),
        .err_count              (chk_errors),
        .resp_count             (chk_resps),
        .pending                (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Two draws fill one block
    function automatic block_data_t random_block();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("CHECK FAILED time %0t signal %s expected 0 actual %b", $time, name, value);
            tb_errors++;
        end
    endtask

    // Handshakes and responses all quiet
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            expect_low("icache_req_ready", icache_req_ready);
            expect_low("dcache_req_ready", dcache_req_ready);
            expect_low("icache_resp_valid", icache_resp_valid);
            expect_low("dcache_resp_valid", dcache_resp_valid);
        end
    endtask

    // Called 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic icache_read(input main_mem_block_addr_t addr);
        int waited;
        waited = 0;
        icache_req_valid      = 1'b1;
        icache_req_block_addr = addr;
        @(negedge clk);
        while (!icache_req_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!icache_req_ready) begin
            $display("%0t: icache read of block %0d was never accepted", $time, addr);
            tb_errors++;
        end
        @(posedge clk);
        #1;
        icache_req_valid = 1'b0;
    endtask

    task automatic dcache_request(input req_type_t kind, input main_mem_block_addr_t addr,
                                  input block_data_t data);
        int waited;
        waited = 0;
        dcache_req_valid      = 1'b1;
        dcache_req_type       = kind;
        dcache_req_block_addr = addr;
        dcache_req_block_data = data;
        @(negedge clk);
        while (!dcache_req_ready && waited < WAIT_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!dcache_req_ready) begin
            $display("%0t: dcache request to block %0d was never accepted", $time, addr);
            tb_errors++;
        end
        @(posedge clk);
        #1;
        dcache_req_valid = 1'b0;
    endtask

    // Until the checker holds no outstanding read
    // Polled on the rising edge since the checker counts on the falling one
    task automatic wait_drained();
        int waited;
        waited = 0;
        @(posedge clk);
        while (chk_pending != 0 && waited < WAIT_LIMIT) begin
            waited++;
            @(posedge clk);
        end
        if (chk_pending != 0) begin
            $display("%0t: %0d reads still outstanding", $time, chk_pending);
            tb_errors++;
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_num++;
        test_name       = name;
        errors_at_start = tb_errors + chk_errors;
    endtask

    task automatic finish_test();
        int errs;
        errs = tb_errors + chk_errors - errors_at_start;
        if (errs == 0) begin
            $display("test %0d %s: passed", test_num, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, test_name, errs);
            tests_failed++;
        end
    endtask

    initial begin
        icache_req_valid      = 1'b0;
        icache_req_block_addr = '0;
        dcache_req_valid      = 1'b0;
        dcache_req_type       = READ;
        dcache_req_block_addr = '0;
        dcache_req_block_data = '0;
        seed                  = 32'hceeb;
        tb_errors             = 0;
        test_num              = 0;
        tests_failed          = 0;
        arst_n                = 1'b0;

        // Quiet through reset
        begin_test("reset and fill");
        check_idle(5);
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        check_idle(5);
        @(posedge clk);
        #1;
        // Every block gets defined data before any read
        for (int a = 0; a < N_BLOCKS; a++) begin
            dcache_request(WRITE, main_mem_block_addr_t'(a), random_block());
        end
        wait_drained();
        finish_test();

        // Isolated reads of old and rewritten data
        begin_test("dcache read");
        for (int i = 0; i < 4; i++) begin
            addr_tmp = main_mem_block_addr_t'($random(seed));
            dcache_request(READ, addr_tmp, '0);
            wait_drained();
            dcache_request(WRITE, addr_tmp, random_block());
            repeat (2) @(posedge clk);
            #1;
            dcache_request(READ, addr_tmp, '0);
            wait_drained();
        end
        finish_test();

        begin_test("icache read");
        for (int i = 0; i < 8; i++) begin
            icache_read(main_mem_block_addr_t'($random(seed)));
            wait_drained();
        end
        finish_test();

        // Both ports held valid so the grants alternate
        begin_test("arbitration");
        fork
            begin
                for (int i = 0; i < 6; i++) begin
                    icache_read(main_mem_block_addr_t'(i * 7));
                end
            end
            begin
                for (int i = 0; i < 6; i++) begin
                    dcache_request(i[0] ? READ : WRITE, main_mem_block_addr_t'(i * 5),
                                   random_block());
                end
            end
        join
        wait_drained();
        finish_test();

        // One read per bank in consecutive cycles
        begin_test("pipelined reads");
        for (int b = 0; b < `MEM_N_BANKS; b++) begin
            dcache_request(READ, main_mem_block_addr_t'(b + 8), '0);
        end
        // Write and read of the same block back to back
        addr_tmp = main_mem_block_addr_t'(21);
        dcache_request(WRITE, addr_tmp, random_block());
        dcache_request(READ, addr_tmp, '0);
        icache_read(addr_tmp);
        wait_drained();
        finish_test();

        begin_test("random traffic");
        for (int i = 0; i < N_HALF; i++) begin
            rnd_ic_addr[i] = main_mem_block_addr_t'($random(seed));
            rnd_ic_gap[i]  = {$random(seed)} % 3;
            rnd_dc_type[i] = req_type_t'($random(seed) & 1);
            rnd_dc_addr[i] = main_mem_block_addr_t'($random(seed));
            rnd_dc_data[i] = random_block();
            rnd_dc_gap[i]  = {$random(seed)} % 3;
        end
        fork
            begin
                for (int i = 0; i < N_HALF; i++) begin
                    icache_read(rnd_ic_addr[i]);
                    if (rnd_ic_gap[i] > 0) begin
                        repeat (rnd_ic_gap[i]) @(posedge clk);
                        #1;
                    end
                end
            end
            begin
                for (int i = 0; i < N_HALF; i++) begin
                    dcache_request(rnd_dc_type[i], rnd_dc_addr[i], rnd_dc_data[i]);
                    if (rnd_dc_gap[i] > 0) begin
                        repeat (rnd_dc_gap[i]) @(posedge clk);
                        #1;
                    end
                end
            end
        join
        wait_drained();
        finish_test();

        $display("tests %0d, failed %0d, responses checked %0d, errors %0d",
                 test_num, tests_failed, chk_resps, tb_errors + chk_errors);
        if (tests_failed == 0 && tb_errors + chk_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_checker import mem_pkg::*; (
    input  wire                          clk,
    input  wire                          arst_n,

    // Icache side of the DUT
    input  wire                          icache_req_valid,
    input  wire main_mem_block_addr_t    icache_req_block_addr,
    input  wire                          icache_req_ready,
    input  wire                          icache_resp_valid,
    input  wire block_data_t             icache_resp_block_data,

    // Dcache side of the DUT
    input  wire                          dcache_req_valid,
    input  wire req_type_t               dcache_req_type,
    input  wire main_mem_block_addr_t    dcache_req_block_addr,
    input  wire block_data_t             dcache_req_block_data,
    input  wire                          dcache_req_ready,
    input  wire                          dcache_resp_valid,
    input  wire block_data_t             dcache_resp_block_data,

    // Running totals for the testbench
    output int                           err_count,
    output int                           resp_count,
    output int                           pending
);

    // Read accepted at edge E answers in the cycle after edge E + latency + 2
    localparam int RESP_DELAY = `MEM_LATENCY + 2;
    localparam int IC = 0;
    localparam int DC = 1;

    // Shadow copy of every block
    block_data_t    shadow [1 << `MEM_ADDR_WIDTH];

    // Per-cache expected data and due cycle, in acceptance order
    block_data_t    exp_q [2][$];
    longint         due_q [2][$];

    longint         cycle_cnt;
    int             errs = 0;
    int             resps = 0;
    int             outstanding = 0;
    logic           grant_known = 1'b0;
    cache_type_t    last_grant = ICACHE;

    assign err_count  = errs;
    assign resp_count = resps;
    assign pending    = outstanding;

    // Reference model of a read, the last block written there
    function automatic block_data_t expected_block(input main_mem_block_addr_t addr);
        return shadow[addr];
    endfunction

    // Rising edges since reset, used to time responses
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

    task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("CHECK FAILED time %0t signal %s expected %h actual %h", $time, name, exp, act);
        errs++;
    endtask

    // Arbitration rules, checked against the port valids
    task automatic check_grant();
        logic exp_ic;
        if (icache_req_ready && !icache_req_valid) begin
            $display("%0t: icache ready raised without a request", $time);
            errs++;
        end
        if (dcache_req_ready && !dcache_req_valid) begin
            $display("%0t: dcache ready raised without a request", $time);
            errs++;
        end
        if (icache_req_valid && dcache_req_valid && grant_known) begin
            // Port passed over last time wins
            exp_ic = (last_grant == DCACHE);
            if (icache_req_ready !== exp_ic) begin
                value_error("icache_req_ready", 64'(exp_ic), 64'(icache_req_ready));
            end
            if (dcache_req_ready !== !exp_ic) begin
                value_error("dcache_req_ready", 64'(!exp_ic), 64'(dcache_req_ready));
            end
        end else if (icache_req_valid && !dcache_req_valid && icache_req_ready !== 1'b1) begin
            value_error("icache_req_ready", 64'd1, 64'(icache_req_ready));
        end else if (dcache_req_valid && !icache_req_valid && dcache_req_ready !== 1'b1) begin
            value_error("dcache_req_ready", 64'd1, 64'(dcache_req_ready));
        end
    endtask

    // One response port against its queue
    task automatic check_response(input int c, input logic valid, input block_data_t data,
                                  input string name);
        // Anything past due never came
        while (due_q[c].size() > 0 && due_q[c][0] < cycle_cnt) begin
            $display("%0t: %s response missing, was due in cycle %0d", $time, name,
                     due_q[c][0]);
            errs++;
            void'(exp_q[c].pop_front());
            void'(due_q[c].pop_front());
        end
        if (valid) begin
            if (due_q[c].size() == 0 || due_q[c][0] != cycle_cnt) begin
                $display("%0t: %s response arrived with no read due", $time, name);
                errs++;
            end else begin
                resps++;
                if (data !== exp_q[c][0]) begin
                    value_error({name, "_block_data"}, 64'(exp_q[c][0]), 64'(data));
                end
                void'(exp_q[c].pop_front());
                void'(due_q[c].pop_front());
            end
        end
    endtask

    // Accepted requests update the model
    task automatic record_requests();
        if (icache_req_valid && icache_req_ready) begin
            exp_q[IC].push_back(expected_block(icache_req_block_addr));
            due_q[IC].push_back(cycle_cnt + 1 + RESP_DELAY);
            last_grant  = ICACHE;
            grant_known = 1'b1;
        end
        if (dcache_req_valid && dcache_req_ready) begin
            if (dcache_req_type == WRITE) begin
                shadow[dcache_req_block_addr] = dcache_req_block_data;
            end else begin
                exp_q[DC].push_back(expected_block(dcache_req_block_addr));
                due_q[DC].push_back(cycle_cnt + 1 + RESP_DELAY);
            end
            last_grant  = DCACHE;
            grant_known = 1'b1;
        end
    endtask

    // Sample mid-cycle, away from both clock edges and input changes
    always @(negedge clk) begin
        if (arst_n) begin
            check_grant();
            check_response(IC, icache_resp_valid, icache_resp_block_data, "icache_resp");
            check_response(DC, dcache_resp_valid, dcache_resp_block_data, "dcache_resp");
            record_requests();
            outstanding = due_q[IC].size() + due_q[DC].size();
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_system.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_system import mem_pkg::*; (
    input  wire                          clk,
    input  wire                          arst_n,

    // Icache request and response
    input  wire                          icache_req_valid,
    input  wire main_mem_block_addr_t    icache_req_block_addr,
    output wire                          icache_req_ready,
    output wire                          icache_resp_valid,
    output wire block_data_t             icache_resp_block_data,

    // Dcache request and response
    input  wire                          dcache_req_valid,
    input  wire req_type_t               dcache_req_type,
    input  wire main_mem_block_addr_t    dcache_req_block_addr,
    input  wire block_data_t             dcache_req_block_data,
    output wire                          dcache_req_ready,
    output wire                          dcache_resp_valid,
    output wire block_data_t             dcache_resp_block_data
);

    // Controller to banks, payload shared
    wire [`MEM_N_BANKS-1:0]          bank_req_valid;
    wire [`MEM_ROW_WIDTH-1:0]        bank_req_row;
    wire req_type_t                  bank_req_type;
    wire cache_type_t                bank_req_cache_type;
    wire block_data_t                bank_req_block_data;

    // Banks to router, one set per bank
    wire [`MEM_N_BANKS-1:0]          bank_resp_valid;
    wire cache_type_t                bank_resp_cache_type [`MEM_N_BANKS];
    wire block_data_t                bank_resp_block_data [`MEM_N_BANKS];

    mem_ctrl u_mem_ctrl (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .icache_req_valid       (icache_req_valid),
        .icache_req_block_addr  (icache_req_block_addr),
        .icache_req_ready       (icache_req_ready),
        .dcache_req_valid       (dcache_req_valid),
        .dcache_req_type        (dcache_req_type),
        .dcache_req_block_addr  (dcache_req_block_addr),
        .dcache_req_block_data  (dcache_req_block_data),
        .dcache_req_ready       (dcache_req_ready),
        .bank_req_valid         (bank_req_valid),
        .bank_req_row           (bank_req_row),
        .bank_req_type          (bank_req_type),
        .bank_req_cache_type    (bank_req_cache_type),
        .bank_req_block_data    (bank_req_block_data)
    );

    // Interleaved banks, each sees only its own strobe
    for (genvar b = 0; b < `MEM_N_BANKS; b++) begin : g_bank
        mem_bank u_mem_bank (
            .clk             (clk),
            .arst_n          (arst_n),
            .req_valid       (bank_req_valid[b]),
            .req_row         (bank_req_row),
            .req_type        (bank_req_type),
            .req_cache_type  (bank_req_cache_type),
            .req_block_data  (bank_req_block_data),
            .resp_valid      (bank_resp_valid[b]),
            .resp_cache_type (bank_resp_cache_type[b]),
            .resp_block_data (bank_resp_block_data[b])
        );
    end

    mem_resp_route u_mem_resp_route (
        .clk                    (clk),
        .arst_n                 (arst_n),
        .bank_resp_valid        (bank_resp_valid),
        .bank_resp_cache_type   (bank_resp_cache_type),
        .bank_resp_block_data   (bank_resp_block_data),
        .icache_resp_valid      (icache_resp_valid),
        .icache_resp_block_data (icache_resp_block_data),
        .dcache_resp_valid      (dcache_resp_valid),
        .dcache_resp_block_data (dcache_resp_block_data)
    );

endmodule

`default_nettype wire

/* hdl/mem_resp_route.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_resp_route import mem_pkg::*; (
    input  wire                          clk,
    input  wire                          arst_n,

    // Raw bank outputs, at most one valid per cycle
    input  wire [`MEM_N_BANKS-1:0]       bank_resp_valid,
    input  wire cache_type_t             bank_resp_cache_type [`MEM_N_BANKS],
    input  wire block_data_t             bank_resp_block_data [`MEM_N_BANKS],

    // Per-cache response pulses, no back-pressure
    output logic                         icache_resp_valid,
    output block_data_t                  icache_resp_block_data,
    output logic                         dcache_resp_valid,
    output block_data_t                  dcache_resp_block_data
);

    logic                            sel_valid;
    cache_type_t                     sel_cache_type;
    block_data_t                     sel_data;
    logic                            to_icache;
    logic                            to_dcache;

    // Pick the one bank that is answering
    always_comb begin
        sel_valid      = 1'b0;
        sel_cache_type = ICACHE;
        sel_data       = '0;
        for (int b = 0; b < `MEM_N_BANKS; b++) begin
            if (bank_resp_valid[b]) begin
                sel_valid      = 1'b1;
                sel_cache_type = bank_resp_cache_type[b];
                sel_data       = bank_resp_block_data[b];
            end
        end
    end

    // Steer by the tag carried through the bank
    assign to_icache = sel_valid && (sel_cache_type == ICACHE);
    assign to_dcache = sel_valid && (sel_cache_type == DCACHE);

    // Response strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            icache_resp_valid <= 1'b0;
            dcache_resp_valid <= 1'b0;
        end else begin
            icache_resp_valid <= to_icache;
            dcache_resp_valid <= to_dcache;
        end
    end

    // Data held until the next response to the same cache
    always_ff @(posedge clk) begin
        if (to_icache) begin
            icache_resp_block_data <= sel_data;
        end
        if (to_dcache) begin
            dcache_resp_block_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_bank import mem_pkg::*; (
    input  wire                          clk,
    input  wire                          arst_n,

    // Request from the controller, one-cycle strobe
    input  wire                          req_valid,
    input  wire [`MEM_ROW_WIDTH-1:0]     req_row,
    input  wire req_type_t               req_type,
    input  wire cache_type_t             req_cache_type,
    input  wire block_data_t             req_block_data,

    // Read response after the fixed latency
    output logic                         resp_valid,
    output cache_type_t                  resp_cache_type,
    output block_data_t                  resp_block_data
);

    // Block storage, undefined until written
    block_data_t                     mem [`MEM_BANK_DEPTH];

    // Stage 0 holds the storage read, stages 1..L delay it
    logic [`MEM_LATENCY:0]           pipe_valid_q;
    cache_type_t                     pipe_cache_type_q [`MEM_LATENCY+1];
    block_data_t                     pipe_data_q [`MEM_LATENCY+1];

    logic                            rd_en;
    logic                            wr_en;

    assign rd_en = req_valid && (req_type == READ);
    assign wr_en = req_valid && (req_type == WRITE);

    // Write lands at the issue edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[req_row] <= req_block_data;
        end
    end

    // Only reads enter the response pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid_q <= '0;
        end else begin
            pipe_valid_q <= {pipe_valid_q[`MEM_LATENCY-1:0], rd_en};
        end
    end

    // Tag and data ride along with the valid bits
    always_ff @(posedge clk) begin
        for (int s = `MEM_LATENCY; s > 0; s--) begin
            pipe_cache_type_q[s] <= pipe_cache_type_q[s-1];
            pipe_data_q[s]       <= pipe_data_q[s-1];
        end
        if (rd_en) begin
            pipe_cache_type_q[0] <= req_cache_type;
            pipe_data_q[0]       <= mem[req_row];
        end
    end

    // Last stage drives the bank outputs
    assign resp_valid      = pipe_valid_q[`MEM_LATENCY];
    assign resp_cache_type = pipe_cache_type_q[`MEM_LATENCY];
    assign resp_block_data = pipe_data_q[`MEM_LATENCY];

endmodule

`default_nettype wire

/* hdl/mem_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module mem_ctrl import mem_pkg::*; (
    input  wire                          clk,
    input  wire                          arst_n,

    // Instruction cache request, always a read
    input  wire                          icache_req_valid,
    input  wire main_mem_block_addr_t    icache_req_block_addr,
    output logic                         icache_req_ready,

    // Data cache request
    input  wire                          dcache_req_valid,
    input  wire req_type_t               dcache_req_type,
    input  wire main_mem_block_addr_t    dcache_req_block_addr,
    input  wire block_data_t             dcache_req_block_data,
    output logic                         dcache_req_ready,

    // Registered request toward the banks
    output logic [`MEM_N_BANKS-1:0]      bank_req_valid,
    output logic [`MEM_ROW_WIDTH-1:0]    bank_req_row,
    output req_type_t                    bank_req_type,
    output cache_type_t                  bank_req_cache_type,
    output block_data_t                  bank_req_block_data
);

    // Port that won the most recent arbitration
    cache_type_t                     last_grant_q;

    logic                            grant_icache;
    logic                            grant_dcache;
    logic                            grant_any;
    main_mem_block_addr_t            sel_block_addr;
    logic [`MEM_BANK_SEL_WIDTH-1:0]  sel_bank;
    logic [`MEM_N_BANKS-1:0]         bank_valid_next;

    // Round robin between the two ports
    // A lone requester always wins
    always_comb begin
        grant_icache = icache_req_valid &&
                       (!dcache_req_valid || last_grant_q == DCACHE);
        grant_dcache = dcache_req_valid &&
                       (!icache_req_valid || last_grant_q == ICACHE);
        grant_any    = grant_icache || grant_dcache;
    end

    // Ready follows the grant in the same cycle
    assign icache_req_ready = grant_icache;
    assign dcache_req_ready = grant_dcache;

    // Address of the granted port
    assign sel_block_addr = grant_dcache ? dcache_req_block_addr : icache_req_block_addr;
    assign sel_bank       = sel_block_addr[`MEM_BANK_SEL_WIDTH-1:0];

    // One-hot bank strobe from the bank select bits
    always_comb begin
        bank_valid_next = '0;
        if (grant_any) begin
            bank_valid_next[sel_bank] = 1'b1;
        end
    end

    // Control state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Icache gets first pick out of reset
            last_grant_q   <= DCACHE;
            bank_req_valid <= '0;
        end else begin
            bank_req_valid <= bank_valid_next;
            if (grant_any) begin
                last_grant_q <= grant_dcache ? DCACHE : ICACHE;
            end
        end
    end

    // Request payload, shared by all banks
    // Only the strobed bank looks at it
    always_ff @(posedge clk) begin
        if (grant_any) begin
            bank_req_row        <= sel_block_addr[`MEM_ADDR_WIDTH-1:`MEM_BANK_SEL_WIDTH];
            bank_req_type       <= grant_dcache ? dcache_req_type : READ;
            bank_req_cache_type <= grant_dcache ? DCACHE : ICACHE;
            bank_req_block_data <= dcache_req_block_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_pkg.sv */
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    // One full cache block
    typedef logic [`MEM_BLOCK_WIDTH-1:0] block_data_t;

    // Block address, bank select in the low bits
    typedef logic [`MEM_ADDR_WIDTH-1:0] main_mem_block_addr_t;

    // 0 is read, 1 is write
    typedef enum logic {
        READ  = 1'b0,
        WRITE = 1'b1
    } req_type_t;

    // Which cache owns a request
    typedef enum logic {
        ICACHE = 1'b0,
        DCACHE = 1'b1
    } cache_type_t;

endpackage

`default_nettype wire

/* hdl/mem_config.svh */
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Main memory geometry and timing

// Bits per cache block
`define MEM_BLOCK_WIDTH 64

// Number of interleaved banks, power of two
`define MEM_N_BANKS 4

// Blocks held by each bank
`define MEM_BANK_DEPTH 16

// Block address bits, bank select plus row
`define MEM_ADDR_WIDTH 6

// Pipeline stages behind the storage read in a bank
`define MEM_LATENCY 3

// Low address bits pick the bank
`define MEM_BANK_SEL_WIDTH $clog2(`MEM_N_BANKS)

// Remaining upper bits pick the row
`define MEM_ROW_WIDTH (`MEM_ADDR_WIDTH - `MEM_BANK_SEL_WIDTH)

`endif
